//--- verilog/snap_defines.svh
`ifndef SNAP_DEFINES_SVH
`define SNAP_DEFINES_SVH

// delay line geometry

`define SNAP_WIDTH  8    // bits per sample
`define SNAP_DEPTH  128  // entries in line and in each page
`define SNAP_AWIDTH 7    // log2 of depth

`define SNAP_PAGES  8    // shadow save slots
`define SNAP_PWIDTH 3    // page select bits

`endif

//--- verilog/snap_pkg.sv
`include "snap_defines.svh"

package snap_pkg;

    typedef logic [`SNAP_WIDTH-1:0] sample_t;

    // command strobes as seen on the top
    typedef struct packed {
        logic                    save_state;
        logic                    restore_state;
        logic [`SNAP_PWIDTH-1:0] save_page;
        logic [`SNAP_PWIDTH-1:0] restore_page;
    } snap_req_t;

    // one transfer access from the sequencer
    typedef struct packed {
        logic [`SNAP_AWIDTH-1:0] addr;
        logic                    we;
        sample_t                 wdata;
    } mem_port_t;

endpackage

//--- verilog/delay_ring.sv
`timescale 1ns/1ps
`include "snap_defines.svh"

module delay_ring (
    input  logic                clk,
    input  logic                reset,
    input  logic                busy,
    input  snap_pkg::sample_t   sample_in,
    input  snap_pkg::mem_port_t ring_port,
    output snap_pkg::sample_t   ring_rdata,
    output snap_pkg::sample_t   sample_out
);

    snap_pkg::sample_t       mem [`SNAP_DEPTH];
    logic [`SNAP_AWIDTH-1:0] ptr;

    // running step is read-then-overwrite at ptr
    // a transfer owns the array while busy is high
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SNAP_DEPTH; i++) begin
                mem[i] <= snap_pkg::sample_t'(32 + i);  // known start pattern
            end
            ptr        <= '0;
            sample_out <= '0;
        end else if (!busy) begin
            sample_out <= mem[ptr];
            mem[ptr]   <= sample_in;
            ptr        <= ptr + 1'b1;  // wraps at depth
        end else if (ring_port.we) begin
            mem[ring_port.addr] <= ring_port.wdata;  // restore word
        end
    end

    assign ring_rdata = mem[ring_port.addr];  // async read for save

    a_write_only_busy: assert property (
        @(posedge clk) disable iff (reset)
        ring_port.we |-> busy
    ) else $error("ring transfer write while not busy");

endmodule

//--- verilog/shadow_pages.sv
`timescale 1ns/1ps
`include "snap_defines.svh"

module shadow_pages (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`SNAP_PWIDTH-1:0] page_sel,
    input  snap_pkg::mem_port_t     page_port,
    output snap_pkg::sample_t       page_rdata
);

    snap_pkg::sample_t mem [`SNAP_PAGES][`SNAP_DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < `SNAP_PAGES; p++) begin
                for (int a = 0; a < `SNAP_DEPTH; a++) begin
                    mem[p][a] <= '0;  // unsaved pages read as zero
                end
            end
        end else if (page_port.we) begin
            mem[page_sel][page_port.addr] <= page_port.wdata;
        end
    end

    always_ff @(posedge clk) begin
        page_rdata <= mem[page_sel][page_port.addr];  // one cycle latency
    end

    // a copy in flight always targets one page
    a_page_steady: assert property (
        @(posedge clk) disable iff (reset)
        (page_port.we && $past(page_port.we)) |-> $stable(page_sel)
    ) else $error("page select changed inside a save");

endmodule

//--- verilog/snapshot_ctrl.sv
`timescale 1ns/1ps
`include "snap_defines.svh"

module snapshot_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  snap_pkg::snap_req_t     req,
    input  snap_pkg::sample_t       ring_rdata,
    input  snap_pkg::sample_t       page_rdata,
    output snap_pkg::mem_port_t     ring_port,
    output snap_pkg::mem_port_t     page_port,
    output logic [`SNAP_PWIDTH-1:0] page_sel,
    output logic                    busy,
    output logic                    done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SAVE,
        ST_RESTORE,
        ST_DRAIN,
        ST_FINISH
    } state_t;

    state_t                  state;
    logic [`SNAP_AWIDTH-1:0] cnt;
    logic [`SNAP_PWIDTH-1:0] page_q;
    logic                    lag_we;
    logic [`SNAP_AWIDTH-1:0] lag_addr;
    logic                    last_word;

    assign last_word = &cnt;  // depth is a power of two

    // save takes priority; strobes are only looked at in idle
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            page_q <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req.save_state) begin
                        state  <= ST_SAVE;
                        page_q <= req.save_page;
                    end else if (req.restore_state) begin
                        state  <= ST_RESTORE;
                        page_q <= req.restore_page;
                    end
                end
                ST_SAVE: begin
                    cnt <= cnt + 1'b1;  // back to zero after last word
                    if (last_word) begin
                        state <= ST_FINISH;
                    end
                end
                ST_RESTORE: begin
                    cnt <= cnt + 1'b1;
                    if (last_word) begin
                        state <= ST_DRAIN;  // last page read still in flight
                    end
                end
                ST_DRAIN: begin
                    state <= ST_FINISH;
                end
                ST_FINISH: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ring write trails the registered page read by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            lag_we <= 1'b0;
        end else begin
            lag_we <= (state == ST_RESTORE);
        end
    end

    always_ff @(posedge clk) begin
        lag_addr <= cnt;
    end

    assign busy     = (state != ST_IDLE);
    assign page_sel = page_q;

    always_comb begin
        page_port.addr  = cnt;
        page_port.we    = (state == ST_SAVE);
        page_port.wdata = ring_rdata;
        ring_port.addr  = (state == ST_SAVE) ? cnt : lag_addr;
        ring_port.we    = lag_we;
        ring_port.wdata = page_rdata;
    end

    a_cnt_rest: assert property (
        @(posedge clk) disable iff (reset)
        !busy |-> (cnt == '0)
    ) else $error("word counter not rewound at idle");

    a_one_writer: assert property (
        @(posedge clk) disable iff (reset)
        !(ring_port.we && page_port.we)
    ) else $error("ring and page written in the same cycle");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (reset)
        done |-> !busy ##1 !done
    ) else $error("done not a single pulse at idle");

endmodule

//--- verilog/delay_snapshot_top.sv
`timescale 1ns/1ps
`include "snap_defines.svh"

module delay_snapshot_top (
    input  logic                clk,
    input  logic                reset,
    input  snap_pkg::snap_req_t req,
    input  snap_pkg::sample_t   sample_in,
    output snap_pkg::sample_t   sample_out,
    output logic                busy,
    output logic                done
);

    snap_pkg::mem_port_t     ring_port;
    snap_pkg::mem_port_t     page_port;
    logic [`SNAP_PWIDTH-1:0] page_sel;
    snap_pkg::sample_t       ring_rdata;
    snap_pkg::sample_t       page_rdata;

    snapshot_ctrl i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .ring_rdata (ring_rdata),
        .page_rdata (page_rdata),
        .ring_port  (ring_port),
        .page_port  (page_port),
        .page_sel   (page_sel),
        .busy       (busy),
        .done       (done)
    );

    delay_ring i_ring (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),  // freezes the line during copies
        .sample_in  (sample_in),
        .ring_port  (ring_port),
        .ring_rdata (ring_rdata),
        .sample_out (sample_out)
    );

    shadow_pages i_pages (
        .clk        (clk),
        .reset      (reset),
        .page_sel   (page_sel),
        .page_port  (page_port),
        .page_rdata (page_rdata)
    );

endmodule

//--- sim/tb_delay_snapshot.sv
`timescale 1ns/1ps
`include "snap_defines.svh"

module tb_delay_snapshot;

    logic                clk;
    logic                reset;
    snap_pkg::snap_req_t req;
    snap_pkg::sample_t   sample_in;
    snap_pkg::sample_t   sample_out;
    logic                busy;
    logic                done;

    // reference model state
    snap_pkg::sample_t       ring_m [`SNAP_DEPTH];
    snap_pkg::sample_t       page_m [`SNAP_PAGES][`SNAP_DEPTH];
    logic [`SNAP_AWIDTH-1:0] ptr_m;

    snap_pkg::sample_t exp_out;
    logic              chk_on;    // compare sample_out
    logic              flags_on;  // expect busy and done low
    logic [15:0]       lfsr;

    int    n_checks;
    int    n_errors;
    int    n_tests;
    int    n_failed;
    int    test_err0;
    string test_name;
    event  abort_run;

    delay_snapshot_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .sample_in  (sample_in),
        .sample_out (sample_out),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16-bit Fibonacci with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic snap_pkg::sample_t rand_byte();
        snap_pkg::sample_t b;
        b = '0;
        for (int i = 0; i < `SNAP_WIDTH; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            b    = {b[`SNAP_WIDTH-2:0], lfsr[15]};
        end
        return b;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `SNAP_DEPTH; i++) begin
            ring_m[i] = snap_pkg::sample_t'(32 + i);
        end
        for (int p = 0; p < `SNAP_PAGES; p++) begin
            for (int a = 0; a < `SNAP_DEPTH; a++) begin
                page_m[p][a] = '0;
            end
        end
        ptr_m = '0;
    endtask

    // one running step moves the old entry out and the new byte in
    function automatic snap_pkg::sample_t model_run(input snap_pkg::sample_t din);
        snap_pkg::sample_t q;
        q             = ring_m[ptr_m];
        ring_m[ptr_m] = din;
        ptr_m         = ptr_m + 1'b1;
        return q;
    endfunction

    task automatic check_sample(input string name, input snap_pkg::sample_t got,
                                input snap_pkg::sample_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0s: got %02h expected %02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("FAIL %0s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == test_err0) begin
            $display("test %0s: ok", test_name);
        end else begin
            n_failed++;
            $display("test %0s: %0d errors", test_name, n_errors - test_err0);
        end
    endtask

    // call on a falling edge; the next rising edge runs the line
    task automatic drive_step(input snap_pkg::sample_t din);
        snap_pkg::sample_t e;
        e = model_run(din);
        sample_in <= din;
        exp_out   <= e;  // seen by the compare on the next falling edge
    endtask

    task automatic run_steps(input int n);
        repeat (n) begin
            @(negedge clk);
            drive_step(rand_byte());
        end
    endtask

    task automatic do_transfer(input logic save, input logic restore,
                               input logic [`SNAP_PWIDTH-1:0] spage,
                               input logic [`SNAP_PWIDTH-1:0] rpage,
                               input logic noise);
        snap_pkg::snap_req_t cmd;
        snap_pkg::snap_req_t junk;
        int                  cycles;
        int                  exp_lat;
        logic                seen;
        cmd               = '0;
        cmd.save_state    = save;
        cmd.restore_state = restore;
        cmd.save_page     = spage;
        cmd.restore_page  = rpage;
        junk              = '1;  // both strobes, page 7
        @(negedge clk);
        req      <= cmd;
        flags_on <= 1'b0;
        drive_step(rand_byte());  // strobe edge still runs the line
        if (save) begin
            for (int a = 0; a < `SNAP_DEPTH; a++) begin
                page_m[spage][a] = ring_m[a];
            end
            exp_lat = `SNAP_DEPTH + 1;
        end else begin
            for (int a = 0; a < `SNAP_DEPTH; a++) begin
                ring_m[a] = page_m[rpage][a];
            end
            exp_lat = `SNAP_DEPTH + 2;  // extra page read cycle
        end
        cycles = -1;  // edges after the one taking the strobe
        seen   = 1'b0;
        while (!seen && cycles < 200) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_flag("busy", busy, 1'b1);
                req       <= (noise && cycles == 20) ? junk : '0;
                sample_in <= rand_byte();  // dropped by the DUT
            end
        end
        if (!seen) begin
            n_errors++;
            $display("timeout: done did not arrive within 200 cycles of the strobe");
            -> abort_run;
        end else begin
            check_flag("busy", busy, 1'b0);
            check_latency("done_latency", cycles, exp_lat);
            req      <= '0;
            flags_on <= 1'b1;
            drive_step(rand_byte());
        end
    endtask

    always @(negedge clk) begin
        if (chk_on) begin
            check_sample("sample_out", sample_out, exp_out);
        end
        if (flags_on) begin
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
        end
    end

    initial begin
        @(abort_run);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        req       = '0;
        sample_in = '0;
        exp_out   = '0;
        chk_on    = 1'b0;
        flags_on  = 1'b0;
        lfsr      = 16'd58758;
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        n_failed  = 0;
        test_err0 = 0;
        model_reset();
        repeat (10) @(negedge clk);

        begin_test("reset_pattern");
        reset    <= 1'b0;
        chk_on   <= 1'b1;
        flags_on <= 1'b1;
        drive_step(rand_byte());  // first step shows entry 0
        run_steps(`SNAP_DEPTH - 1);
        end_test();

        begin_test("delay_128");
        run_steps(300);
        end_test();

        begin_test("save_restore");
        do_transfer(1'b1, 1'b0, 3'd3, 3'd0, 1'b0);
        run_steps(200);
        do_transfer(1'b0, 1'b1, 3'd0, 3'd3, 1'b0);
        run_steps(200);
        end_test();

        begin_test("empty_page");
        do_transfer(1'b0, 1'b1, 3'd0, 3'd6, 1'b0);
        run_steps(140);  // whole line reads back as zero
        end_test();

        begin_test("latency");
        do_transfer(1'b1, 1'b0, 3'd1, 3'd0, 1'b0);
        run_steps(10);
        do_transfer(1'b0, 1'b1, 3'd0, 3'd1, 1'b0);
        run_steps(10);
        end_test();

        begin_test("busy_ignore");
        do_transfer(1'b1, 1'b0, 3'd4, 3'd0, 1'b1);
        run_steps(50);
        do_transfer(1'b1, 1'b1, 3'd5, 3'd2, 1'b0);  // save must win
        run_steps(150);
        do_transfer(1'b0, 1'b1, 3'd0, 3'd5, 1'b0);
        run_steps(150);
        end_test();

        @(negedge clk);
        chk_on   <= 1'b0;  // last step still compared on this edge
        flags_on <= 1'b0;
        @(negedge clk);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/snap_pkg.sv
verilog/delay_ring.sv
verilog/shadow_pages.sv
verilog/snapshot_ctrl.sv
verilog/delay_snapshot_top.sv
sim/tb_delay_snapshot.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the delay line testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_delay_snapshot \
    -o tb_delay_snapshot

./obj_dir/tb_delay_snapshot | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: FAIL"
    exit 1
fi
